//--- source/lc3b_isa_pkg.sv
`default_nettype none

package lc3b_isa_pkg;

    typedef logic [15:0] lc3b_word;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ld   = 4'b0010,
        op_st   = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef logic [2:0] lc3b_nzp;

    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_nzp    nzp;
        logic [8:0] offset;
    } lc3b_br_view_t;

    typedef struct packed {
        lc3b_opcode opcode;
        logic [2:0] unused_hi;
        logic [2:0] base_r;
        logic [5:0] unused_lo;
    } lc3b_jmp_view_t;

    typedef union packed {
        lc3b_br_view_t  br;
        lc3b_jmp_view_t jmp;
    } lc3b_instr_u;

    // br with an empty nzp mask never branches
    function automatic logic is_cond_br(input lc3b_instr_u w);
        return (w.br.opcode == op_br) && (w.br.nzp != 3'b000);
    endfunction

    function automatic logic is_ctrl_xfer(input lc3b_instr_u w);
        return w.jmp.opcode inside {op_jmp, op_jsr, op_trap};
    endfunction

endpackage

`default_nettype wire

//--- source/branch_pred_pkg.sv
`default_nettype none

package branch_pred_pkg;

    // table indexed by fetch pc bits 5:1
    localparam int PHT_INDEX_BITS = 5;
    localparam int PHT_ENTRIES    = 1 << PHT_INDEX_BITS;

    typedef logic [1:0] pred_ctr_t;

    localparam pred_ctr_t CTR_STRONG_NT = 2'b00;
    localparam pred_ctr_t CTR_WEAK_NT   = 2'b01;
    localparam pred_ctr_t CTR_STRONG_T  = 2'b11;

    typedef enum logic {
        MODE_STATIC  = 1'b0,
        MODE_DYNAMIC = 1'b1
    } pred_mode_e;

endpackage

`default_nettype wire

//--- source/branch_predictor.sv
`default_nettype none

module branch_predictor (
    input  wire logic                        clk,
    input  wire logic                        i_arst_n,
    input  wire lc3b_isa_pkg::lc3b_word      i_fetch_pc,
    input  wire logic                        i_br_fetch,
    input  wire logic                        i_br_taken,
    input  wire logic                        i_br_not_taken,
    input  wire branch_pred_pkg::pred_mode_e i_mode,
    input  wire logic                        i_clear_start,
    output logic                             o_prediction,
    output logic                             o_branch_in_flight,
    output logic                             o_clear_busy
);

    import branch_pred_pkg::*;

    pred_ctr_t                 pht [PHT_ENTRIES];
    logic [PHT_INDEX_BITS-1:0] fetch_idx;
    logic [PHT_INDEX_BITS-1:0] idx_q;
    logic [PHT_INDEX_BITS-1:0] clr_idx;
    logic                      clr_busy;
    logic                      resolve;
    logic                      capture;

    assign fetch_idx = i_fetch_pc[PHT_INDEX_BITS:1];
    assign resolve   = i_br_taken || i_br_not_taken;
    // one branch tracked at a time
    assign capture   = i_br_fetch && !o_branch_in_flight && !resolve;

    assign o_clear_busy = clr_busy;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_branch_in_flight <= 1'b0;
            o_prediction       <= 1'b0;
        end else if (resolve) begin
            o_branch_in_flight <= 1'b0;
            o_prediction       <= 1'b0;
        end else if (capture) begin
            o_branch_in_flight <= 1'b1;
            o_prediction       <= (i_mode == MODE_DYNAMIC) ? pht[fetch_idx][1] : 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            idx_q <= fetch_idx;
        end
    end

    // clear sweep, one entry per cycle
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            clr_busy <= 1'b0;
            clr_idx  <= '0;
        end else if (i_clear_start) begin
            clr_busy <= 1'b1;
            clr_idx  <= '0;
        end else if (clr_busy) begin
            clr_idx <= clr_idx + 1'b1;
            if (clr_idx == PHT_INDEX_BITS'(PHT_ENTRIES - 1)) begin
                clr_busy <= 1'b0;
            end
        end
    end

    // sweep wins over training
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht[i] <= CTR_WEAK_NT;
            end
        end else if (clr_busy) begin
            pht[clr_idx] <= CTR_WEAK_NT;
        end else if (o_branch_in_flight && i_br_taken) begin
            if (pht[idx_q] != CTR_STRONG_T) begin
                pht[idx_q] <= pht[idx_q] + 2'd1;
            end
        end else if (o_branch_in_flight && i_br_not_taken) begin
            if (pht[idx_q] != CTR_STRONG_NT) begin
                pht[idx_q] <= pht[idx_q] - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/predictor_ctrl_regs.sv
`default_nettype none

module predictor_ctrl_regs (
    input  wire logic                   clk,
    input  wire logic                   i_arst_n,
    input  wire logic                   i_cfg_valid,
    input  wire logic                   i_cfg_mode,
    input  wire logic                   i_cfg_clear,
    input  wire logic                   i_clear_busy,
    output logic                        o_cfg_ready,
    output branch_pred_pkg::pred_mode_e o_pred_mode,
    output logic                        o_pht_clear
);

    import branch_pred_pkg::*;

    logic accept;
    logic clear_q;

    // no new write until the sweep has finished
    assign o_cfg_ready = !(i_clear_busy || clear_q);
    assign accept      = i_cfg_valid && o_cfg_ready;

    // single cycle, a handshake cannot repeat while busy
    assign o_pht_clear = accept && i_cfg_clear;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pred_mode <= MODE_STATIC;
            clear_q     <= 1'b0;
        end else begin
            clear_q <= o_pht_clear;
            if (accept) begin
                o_pred_mode <= pred_mode_e'(i_cfg_mode);
            end
        end
    end

endmodule

`default_nettype wire

//--- source/hazard_detection.sv
`default_nettype none

module hazard_detection (
    input  wire logic                       clk,
    input  wire logic                       i_arst_n,

    input  wire lc3b_isa_pkg::lc3b_word     i_instr_if,
    input  wire lc3b_isa_pkg::lc3b_word     i_instr_id,
    input  wire lc3b_isa_pkg::lc3b_word     i_instr_ex,
    input  wire lc3b_isa_pkg::lc3b_word     i_instr_mem,
    input  wire lc3b_isa_pkg::lc3b_word     i_instr_mem_inter,
    input  wire lc3b_isa_pkg::lc3b_word     i_instr_wb,

    input  wire logic                       i_br_enable,
    input  wire logic                       i_imem_resp,
    input  wire logic                       i_dmem_resp,
    input  wire logic                       i_dmem_read,
    input  wire logic                       i_dmem_write,
    input  wire logic                       i_mem_inter_read,
    input  wire logic                       i_mem_inter_write,
    input  wire lc3b_isa_pkg::lc3b_word     i_fetch_pc,

    input  wire branch_pred_pkg::pred_mode_e i_pred_mode,
    input  wire logic                       i_pht_clear,

    output logic                            o_load,
    output logic                            o_load_pc,
    output logic                            o_load_mem_wb_force,
    output logic                            o_ctrl_redirect_wb,
    output logic                            o_flush,
    output logic                            o_flush_mem_op,
    output logic                            o_imem_read,
    output logic                            o_prediction,
    output logic                            o_branch_in_flight,
    output logic                            o_clear_busy
);

    import lc3b_isa_pkg::*;

    lc3b_instr_u w_if;
    lc3b_instr_u w_id;
    lc3b_instr_u w_ex;
    lc3b_instr_u w_mem;
    lc3b_instr_u w_mem_inter;
    lc3b_instr_u w_wb;

    logic br_fetch;
    logic mem_op;
    logic ind_in_mem;
    logic ind_release;
    logic wb_taken;
    logic wb_not_taken;
    logic mispredict;
    logic older_br_pending;

    assign w_if        = i_instr_if;
    assign w_id        = i_instr_id;
    assign w_ex        = i_instr_ex;
    assign w_mem       = i_instr_mem;
    assign w_mem_inter = i_instr_mem_inter;
    assign w_wb        = i_instr_wb;

    assign br_fetch = is_cond_br(w_if);
    assign mem_op   = i_dmem_read || i_dmem_write;

    // ldi/sti occupy MEM until the indirect stage has done both accesses
    assign ind_in_mem  = w_mem.br.opcode inside {op_ldi, op_sti};
    assign ind_release = (w_mem_inter.br.opcode inside {op_ldi, op_sti})
                         && !i_mem_inter_read && !i_mem_inter_write && i_dmem_resp;

    assign wb_taken     = is_cond_br(w_wb) && i_br_enable;
    assign wb_not_taken = is_cond_br(w_wb) && !i_br_enable;

    assign mispredict = (wb_taken && !o_prediction) || (wb_not_taken && o_prediction);

    // a branch still on its way to WB, none resolving now
    assign older_br_pending = (is_cond_br(w_id) || is_cond_br(w_ex) || is_cond_br(w_mem))
                              && !is_cond_br(w_wb);

    // fetch gating and redirect
    always_comb begin
        o_imem_read        = 1'b1;
        o_ctrl_redirect_wb = 1'b0;

        if (is_ctrl_xfer(w_id) || is_ctrl_xfer(w_ex) || is_ctrl_xfer(w_mem)) begin
            o_imem_read = 1'b0;
        end

        if (is_ctrl_xfer(w_wb) || wb_taken) begin
            o_imem_read        = 1'b0;
            o_ctrl_redirect_wb = 1'b1;
        end
    end

    // stalls and flushes
    always_comb begin
        o_load    = !(mem_op && !i_dmem_resp);
        o_load_pc = o_load && i_imem_resp;

        if (ind_in_mem) begin
            o_load    = 1'b0;
            o_load_pc = 1'b0;
        end

        if (ind_release) begin
            o_load    = 1'b1;
            o_load_pc = i_imem_resp;
        end

        o_flush        = mispredict;
        o_flush_mem_op = mispredict;

        if (mispredict || o_ctrl_redirect_wb) begin
            o_load_pc = 1'b1;
        end

        // hold pc while fetch waits on an older jump
        if (!o_imem_read && !o_ctrl_redirect_wb) begin
            o_load_pc = 1'b0;
        end

        o_load_mem_wb_force = 1'b1;
        if (!i_imem_resp && o_imem_read && older_br_pending) begin
            o_load              = 1'b0;
            o_load_pc           = 1'b0;
            o_load_mem_wb_force = 1'b0;
        end
    end

    branch_predictor u_branch_predictor (
        .clk                (clk),
        .i_arst_n           (i_arst_n),
        .i_fetch_pc         (i_fetch_pc),
        .i_br_fetch         (br_fetch),
        .i_br_taken         (wb_taken),
        .i_br_not_taken     (wb_not_taken),
        .i_mode             (i_pred_mode),
        .i_clear_start      (i_pht_clear),
        .o_prediction       (o_prediction),
        .o_branch_in_flight (o_branch_in_flight),
        .o_clear_busy       (o_clear_busy)
    );

endmodule

`default_nettype wire

//--- source/hazard_unit_top.sv
`default_nettype none

module hazard_unit_top (
    input  wire logic                   clk,
    input  wire logic                   i_arst_n,

    input  wire lc3b_isa_pkg::lc3b_word i_instr_if,
    input  wire lc3b_isa_pkg::lc3b_word i_instr_id,
    input  wire lc3b_isa_pkg::lc3b_word i_instr_ex,
    input  wire lc3b_isa_pkg::lc3b_word i_instr_mem,
    input  wire lc3b_isa_pkg::lc3b_word i_instr_mem_inter,
    input  wire lc3b_isa_pkg::lc3b_word i_instr_wb,

    input  wire logic                   i_br_enable,
    input  wire logic                   i_imem_resp,
    input  wire logic                   i_dmem_resp,
    input  wire logic                   i_dmem_read,
    input  wire logic                   i_dmem_write,
    input  wire logic                   i_mem_inter_read,
    input  wire logic                   i_mem_inter_write,
    input  wire lc3b_isa_pkg::lc3b_word i_fetch_pc,

    input  wire logic                   i_cfg_valid,
    input  wire logic                   i_cfg_mode,
    input  wire logic                   i_cfg_clear,
    output logic                        o_cfg_ready,

    output logic                        o_load,
    output logic                        o_load_pc,
    output logic                        o_load_mem_wb_force,
    output logic                        o_ctrl_redirect_wb,
    output logic                        o_flush,
    output logic                        o_flush_mem_op,
    output logic                        o_imem_read,
    output logic                        o_prediction,
    output logic                        o_branch_in_flight
);

    import branch_pred_pkg::*;

    pred_mode_e pred_mode;
    logic       pht_clear;
    logic       clear_busy;

    hazard_detection u_hazard_detection (
        .clk                 (clk),
        .i_arst_n            (i_arst_n),
        .i_instr_if          (i_instr_if),
        .i_instr_id          (i_instr_id),
        .i_instr_ex          (i_instr_ex),
        .i_instr_mem         (i_instr_mem),
        .i_instr_mem_inter   (i_instr_mem_inter),
        .i_instr_wb          (i_instr_wb),
        .i_br_enable         (i_br_enable),
        .i_imem_resp         (i_imem_resp),
        .i_dmem_resp         (i_dmem_resp),
        .i_dmem_read         (i_dmem_read),
        .i_dmem_write        (i_dmem_write),
        .i_mem_inter_read    (i_mem_inter_read),
        .i_mem_inter_write   (i_mem_inter_write),
        .i_fetch_pc          (i_fetch_pc),
        .i_pred_mode         (pred_mode),
        .i_pht_clear         (pht_clear),
        .o_load              (o_load),
        .o_load_pc           (o_load_pc),
        .o_load_mem_wb_force (o_load_mem_wb_force),
        .o_ctrl_redirect_wb  (o_ctrl_redirect_wb),
        .o_flush             (o_flush),
        .o_flush_mem_op      (o_flush_mem_op),
        .o_imem_read         (o_imem_read),
        .o_prediction        (o_prediction),
        .o_branch_in_flight  (o_branch_in_flight),
        .o_clear_busy        (clear_busy)
    );

    predictor_ctrl_regs u_predictor_ctrl_regs (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_cfg_valid  (i_cfg_valid),
        .i_cfg_mode   (i_cfg_mode),
        .i_cfg_clear  (i_cfg_clear),
        .i_clear_busy (clear_busy),
        .o_cfg_ready  (o_cfg_ready),
        .o_pred_mode  (pred_mode),
        .o_pht_clear  (pht_clear)
    );

endmodule

`default_nettype wire

//--- verification/hazard_unit_asserts.sv
`default_nettype none

module hazard_unit_asserts (
    input wire logic                   clk,
    input wire logic                   i_arst_n,
    input wire lc3b_isa_pkg::lc3b_word i_instr_if,
    input wire lc3b_isa_pkg::lc3b_word i_instr_id,
    input wire lc3b_isa_pkg::lc3b_word i_instr_ex,
    input wire lc3b_isa_pkg::lc3b_word i_instr_mem,
    input wire lc3b_isa_pkg::lc3b_word i_instr_mem_inter,
    input wire lc3b_isa_pkg::lc3b_word i_instr_wb,
    input wire logic                   i_br_enable,
    input wire logic                   i_imem_resp,
    input wire logic                   i_dmem_resp,
    input wire logic                   i_dmem_read,
    input wire logic                   i_dmem_write,
    input wire lc3b_isa_pkg::lc3b_word i_fetch_pc,
    input wire logic                   i_cfg_valid,
    input wire logic                   i_cfg_mode,
    input wire logic                   i_cfg_clear,
    input wire logic                   o_cfg_ready,
    input wire logic                   o_load,
    input wire logic                   o_load_pc,
    input wire logic                   o_load_mem_wb_force,
    input wire logic                   o_ctrl_redirect_wb,
    input wire logic                   o_flush,
    input wire logic                   o_flush_mem_op,
    input wire logic                   o_imem_read,
    input wire logic                   o_prediction,
    input wire logic                   o_branch_in_flight
);

    import lc3b_isa_pkg::*;
    import branch_pred_pkg::*;

    int fails = 0;

    logic                      inflight_m;
    logic                      pred_m;
    logic [PHT_INDEX_BITS-1:0] idx_m;
    pred_ctr_t                 ctr_m [PHT_ENTRIES];
    pred_mode_e                mode_m;
    logic                      resolve;
    logic                      exp_flush;

    function automatic logic cond_br(input lc3b_instr_u w);
        return (w.br.opcode == op_br) && (|w.br.nzp);
    endfunction

    function automatic logic jump_op(input lc3b_instr_u w);
        return w.jmp.opcode inside {op_jmp, op_jsr, op_trap};
    endfunction

    function automatic logic indirect_op(input lc3b_instr_u w);
        return w.br.opcode inside {op_ldi, op_sti};
    endfunction

    assign resolve   = cond_br(i_instr_wb);
    assign exp_flush = resolve && (i_br_enable != pred_m);

    // expected predictor state
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            inflight_m <= 1'b0;
            pred_m     <= 1'b0;
            idx_m      <= '0;
            mode_m     <= MODE_STATIC;
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                ctr_m[i] <= CTR_WEAK_NT;
            end
        end else begin
            if (i_cfg_valid && o_cfg_ready) begin
                mode_m <= pred_mode_e'(i_cfg_mode);
            end
            if (resolve) begin
                inflight_m <= 1'b0;
                pred_m     <= 1'b0;
                if (inflight_m && i_br_enable) begin
                    ctr_m[idx_m] <= (ctr_m[idx_m] == 2'b11) ? 2'b11 : ctr_m[idx_m] + 2'd1;
                end else if (inflight_m) begin
                    ctr_m[idx_m] <= (ctr_m[idx_m] == 2'b00) ? 2'b00 : ctr_m[idx_m] - 2'd1;
                end
            end else if (cond_br(i_instr_if) && !inflight_m) begin
                inflight_m <= 1'b1;
                idx_m      <= i_fetch_pc[PHT_INDEX_BITS:1];
                pred_m     <= (mode_m == MODE_DYNAMIC) && ctr_m[i_fetch_pc[PHT_INDEX_BITS:1]][1];
            end
            // whole table back to weak not-taken
            if (i_cfg_valid && o_cfg_ready && i_cfg_clear) begin
                for (int i = 0; i < PHT_ENTRIES; i++) begin
                    ctr_m[i] <= CTR_WEAK_NT;
                end
            end
        end
    end

    a_reset_state: assert property (@(posedge clk) !i_arst_n |-> !o_flush && !o_flush_mem_op
        && !o_branch_in_flight && !o_prediction && o_cfg_ready && o_imem_read)
    else begin
        $error("** Error reset_state: expected 0 0 0 0 1 1, actual %0b %0b %0b %0b %0b %0b",
            $sampled(o_flush), $sampled(o_flush_mem_op), $sampled(o_branch_in_flight),
            $sampled(o_prediction), $sampled(o_cfg_ready), $sampled(o_imem_read));
        fails++;
    end

    a_data_stall: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_dmem_read || i_dmem_write) && !i_dmem_resp |-> !o_load)
    else begin
        $error("** Error data_stall: expected load 0, actual %0b", $sampled(o_load));
        fails++;
    end

    a_indirect_stall: assert property (@(posedge clk) disable iff (!i_arst_n)
        indirect_op(i_instr_mem) && !indirect_op(i_instr_mem_inter) && !o_ctrl_redirect_wb
        && !o_flush |-> !o_load && !o_load_pc)
    else begin
        $error("** Error indirect_stall: expected load 0 load_pc 0, actual %0b %0b",
            $sampled(o_load), $sampled(o_load_pc));
        fails++;
    end

    // pending branch and a fetch without response freeze every stage
    a_fetch_stall: assert property (@(posedge clk) disable iff (!i_arst_n)
        (cond_br(i_instr_id) || cond_br(i_instr_ex) || cond_br(i_instr_mem))
        && !cond_br(i_instr_wb) && o_imem_read && !i_imem_resp
        |-> !o_load && !o_load_pc && !o_load_mem_wb_force)
    else begin
        $error("** Error fetch_stall: expected 0 0 0, actual load %0b load_pc %0b force %0b",
            $sampled(o_load), $sampled(o_load_pc), $sampled(o_load_mem_wb_force));
        fails++;
    end

    a_redirect_wb: assert property (@(posedge clk) disable iff (!i_arst_n)
        jump_op(i_instr_wb) |-> o_ctrl_redirect_wb && !o_imem_read)
    else begin
        $error("** Error redirect_wb: expected redirect 1 imem_read 0, actual %0b %0b",
            $sampled(o_ctrl_redirect_wb), $sampled(o_imem_read));
        fails++;
    end

    a_fetch_gate: assert property (@(posedge clk) disable iff (!i_arst_n)
        jump_op(i_instr_id) || jump_op(i_instr_ex) || jump_op(i_instr_mem) |-> !o_imem_read)
    else begin
        $error("** Error fetch_gate: expected imem_read 0, actual %0b", $sampled(o_imem_read));
        fails++;
    end

    a_prediction: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_prediction == pred_m && o_branch_in_flight == inflight_m)
    else begin
        $error("** Error prediction: expected pred %0b flight %0b, actual pred %0b flight %0b",
            $sampled(pred_m), $sampled(inflight_m),
            $sampled(o_prediction), $sampled(o_branch_in_flight));
        fails++;
    end

    a_flush: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_flush == exp_flush && o_flush_mem_op == exp_flush)
    else begin
        $error("** Error flush: expected %0b, actual flush %0b flush_mem_op %0b",
            $sampled(exp_flush), $sampled(o_flush), $sampled(o_flush_mem_op));
        fails++;
    end

    a_clear_window: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_cfg_ready && i_cfg_valid && i_cfg_clear |=> !o_cfg_ready [*PHT_ENTRIES] ##1 o_cfg_ready)
    else begin
        $error("** Error clear_window: expected ready low 32 cycles then 1, actual %0b",
            $sampled(o_cfg_ready));
        fails++;
    end

endmodule

bind hazard_unit_top hazard_unit_asserts u_asserts (.*);

`default_nettype wire

//--- verification/hazard_unit_tb.sv
`default_nettype none

module hazard_unit_tb;

    import lc3b_isa_pkg::*;

    localparam int       WAIT_LIMIT = 100;
    localparam lc3b_word BR_NZP     = {op_br, 3'b111, 9'h004};
    localparam lc3b_word TRAINED_PC = 16'h0024;

    logic     clk;
    logic     i_arst_n;
    lc3b_word i_instr_if;
    lc3b_word i_instr_id;
    lc3b_word i_instr_ex;
    lc3b_word i_instr_mem;
    lc3b_word i_instr_mem_inter;
    lc3b_word i_instr_wb;
    logic     i_br_enable;
    logic     i_imem_resp;
    logic     i_dmem_resp;
    logic     i_dmem_read;
    logic     i_dmem_write;
    logic     i_mem_inter_read;
    logic     i_mem_inter_write;
    lc3b_word i_fetch_pc;
    logic     i_cfg_valid;
    logic     i_cfg_mode;
    logic     i_cfg_clear;
    logic     o_cfg_ready;
    logic     o_load;
    logic     o_load_pc;
    logic     o_load_mem_wb_force;
    logic     o_ctrl_redirect_wb;
    logic     o_flush;
    logic     o_flush_mem_op;
    logic     o_imem_read;
    logic     o_prediction;
    logic     o_branch_in_flight;
    int       timeouts;
    int       assert_fails;

    hazard_unit_top u_hazard_unit_top (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    // alu-type words that never branch, jump or touch memory
    function automatic lc3b_word filler_word();
        lc3b_opcode op;
        case ($urandom_range(3))
            0: op = op_add;
            1: op = op_and;
            2: op = op_not;
            default: op = op_lea;
        endcase
        return {op, 12'($urandom)};
    endfunction

    task automatic idle_pipe();
        i_instr_if        = filler_word();
        i_instr_id        = filler_word();
        i_instr_ex        = filler_word();
        i_instr_mem       = filler_word();
        i_instr_mem_inter = filler_word();
        i_instr_wb        = filler_word();
        i_br_enable       = 1'b0;
        i_imem_resp       = 1'b1;
        i_dmem_resp       = 1'b0;
        i_dmem_read       = 1'b0;
        i_dmem_write      = 1'b0;
        i_mem_inter_read  = 1'b0;
        i_mem_inter_write = 1'b0;
    endtask

    task automatic cfg_write(input logic mode, input logic clear);
        int   waited;
        logic accepted;
        waited      = 0;
        accepted    = 1'b0;
        i_cfg_valid = 1'b1;
        i_cfg_mode  = mode;
        i_cfg_clear = clear;
        // valid stays up through back-pressure
        while (!accepted && waited < WAIT_LIMIT) begin
            accepted = o_cfg_ready;
            next_cycle();
            waited++;
        end
        i_cfg_valid = 1'b0;
        i_cfg_clear = 1'b0;
        if (!accepted) begin
            $display("timeout: configuration write was never accepted");
            timeouts++;
        end
    endtask

    // fetch a branch and resolve it in WB one cycle later
    task automatic run_branch(input lc3b_word pc, input logic taken);
        i_instr_if = BR_NZP;
        i_fetch_pc = pc;
        next_cycle();
        i_instr_if  = filler_word();
        i_instr_wb  = BR_NZP;
        i_br_enable = taken;
        next_cycle();
        i_instr_wb  = filler_word();
        i_br_enable = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h32067dd7));
        timeouts    = 0;
        i_arst_n    = 1'b0;
        i_fetch_pc  = '0;
        i_cfg_valid = 1'b0;
        i_cfg_mode  = 1'b0;
        i_cfg_clear = 1'b0;
        idle_pipe();
        repeat (16) @(posedge clk);
        #10;
        i_arst_n = 1'b1;
        next_cycle();

        i_dmem_read = 1'b1;
        next_cycle();
        i_dmem_read = 1'b0;
        i_instr_mem = {op_ldi, 12'h123};
        next_cycle();
        idle_pipe();

        i_instr_wb = {op_jmp, 3'b000, 3'b011, 6'b000000};
        next_cycle();
        i_instr_wb = {op_jsr, 12'h801};
        next_cycle();
        i_instr_wb = {op_trap, 12'h025};
        next_cycle();
        idle_pipe();
        i_instr_id = {op_jsr, 12'h801};
        next_cycle();
        idle_pipe();

        // branch in EX while the fetch waits
        i_instr_ex  = BR_NZP;
        i_imem_resp = 1'b0;
        next_cycle();
        idle_pipe();

        // taken then not taken in static mode
        run_branch(TRAINED_PC, 1'b1);
        run_branch(TRAINED_PC, 1'b0);

        cfg_write(1'b1, 1'b0);
        repeat (3) run_branch(TRAINED_PC, 1'b1);

        // second write waits out the sweep
        cfg_write(1'b1, 1'b1);
        cfg_write(1'b1, 1'b0);
        run_branch(TRAINED_PC, 1'b0);
        repeat (4) next_cycle();

        assert_fails = u_hazard_unit_top.u_asserts.fails;
        $display("assertion failures: %0d, timeouts: %0d", assert_fails, timeouts);
        if (assert_fails == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
source/lc3b_isa_pkg.sv
source/branch_pred_pkg.sv
source/branch_predictor.sv
source/predictor_ctrl_regs.sv
source/hazard_detection.sv
source/hazard_unit_top.sv
verification/hazard_unit_asserts.sv
verification/hazard_unit_tb.sv
